// ==== rf_pkg.sv ====
/*
   register file geometry and the request structs shared by all stages
   x0 is stored like any other register; only its error flags are masked
   write requests carry their own enable, there is no handshake
*/
package rf_pkg;

   localparam int XLEN         = 32;   // data word width
   localparam int RF_ADDR_W    = 5;    // register address width
   localparam int RF_DEPTH     = 32;   // number of registers incl. x0
   localparam int N_FWD_STAGES = 3;    // EX, MA and WB destinations

   typedef logic [RF_ADDR_W-1:0] rf_add_t;

   // one write port request, also used as the repair register
   typedef struct packed {
      logic            we;    // write enable (pending flag in the repair register)
      rf_add_t         add;   // destination register
      logic [XLEN-1:0] val;   // value to store
   } rf_wr_t;

   // destination of an instruction still in flight
   typedef struct packed {
      logic    dest_valid;    // instruction writes a register
      rf_add_t add;           // that register
   } stage_dst_t;

endpackage

// ==== secded_pkg.sv ====
/*
   Hsiao (39,32) SECDED code over one XLEN data word
   data columns are the first 32 weight-3 patterns, check bits are one-hot
   a syndrome matching no column is treated as uncorrectable
   all functions are pure combinational
*/
package secded_pkg;
   import rf_pkg::*;

   localparam int CHK_W = 7;    // checksum bits per word

   typedef logic [CHK_W-1:0] chk_t;

   // error flags of one read port
   typedef struct packed {
      logic uce;    // double or worse error
      logic ce;     // single-bit error, correctable
   } rp_info_t;

   // parity check matrix, one column per data bit
   localparam chk_t H_COL [XLEN] = '{
      7'h07, 7'h0B, 7'h0D, 7'h0E, 7'h13, 7'h15, 7'h16, 7'h19,
      7'h1A, 7'h1C, 7'h23, 7'h25, 7'h26, 7'h29, 7'h2A, 7'h2C,
      7'h31, 7'h32, 7'h34, 7'h38, 7'h43, 7'h45, 7'h46, 7'h49,
      7'h4A, 7'h4C, 7'h51, 7'h52, 7'h54, 7'h58, 7'h61, 7'h62
   };

   // checksum of a data word, zero word gives zero checksum
   function automatic chk_t secded_checksum(logic [XLEN-1:0] data);
      chk_t chk;
      chk = '0;
      for (int i = 0; i < XLEN; i++) begin
         if (data[i]) chk ^= H_COL[i];
      end
      return chk;
   endfunction

   // high when the syndrome is clean or points at exactly one bit
   function automatic logic secded_syndrome_ok(chk_t syn);
      logic ok;
      ok = (syn == '0);
      for (int j = 0; j < CHK_W; j++) begin
         if (syn == chk_t'(1 << j)) ok = 1'b1;   // flipped check bit
      end
      for (int i = 0; i < XLEN; i++) begin
         if (syn == H_COL[i]) ok = 1'b1;         // flipped data bit
      end
      return ok;
   endfunction

   // flips the data bit named by the syndrome, otherwise passes data through
   function automatic logic [XLEN-1:0] secded_correct(logic [XLEN-1:0] data, chk_t syn);
      logic [XLEN-1:0] fixed;
      fixed = data;
      for (int i = 0; i < XLEN; i++) begin
         if (syn == H_COL[i]) fixed[i] = ~data[i];
      end
      return fixed;
   endfunction

endpackage

// ==== rf_storage.sv ====
/*
   data and checksum arrays, one write port and two asynchronous read ports
   checksum is computed from the write value at the clock edge
   fault injection flips data bits only and loses to a write to the same register
   reset clears every word, zero data has a zero checksum
*/
`timescale 1ns/10ps

module rf_storage
   import rf_pkg::*;
   import secded_pkg::*;
(
   input  logic            s_clk_i,          // clock
   input  logic            rst_n_i,          // async reset, active low
   input  rf_wr_t          wr_i,             // merged writeback / repair write
   input  logic            inj_en_i,         // fault injection strobe
   input  rf_add_t         inj_add_i,        // register to upset
   input  logic [XLEN-1:0] inj_mask_i,       // bits to flip
   input  rf_add_t         rd_add_i [2],     // read addresses
   output logic [XLEN-1:0] rd_val_o [2],     // raw stored words
   output chk_t            rd_chk_o [2]      // stored checksums
);

   logic [XLEN-1:0] data_q [RF_DEPTH];       // data array
   chk_t            chk_q  [RF_DEPTH];       // checksum array
   logic            inj_hit;

   // upset is dropped when the write port targets the same register
   assign inj_hit = inj_en_i & ~(wr_i.we & (wr_i.add == inj_add_i));

   always_ff @(posedge s_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         data_q <= '{default: '0};
         chk_q  <= '{default: '0};
      end else begin
         if (wr_i.we) begin
            data_q[wr_i.add] <= wr_i.val;
            chk_q[wr_i.add]  <= secded_checksum(wr_i.val);   // keep code in step
         end
         if (inj_hit) begin
            data_q[inj_add_i] <= data_q[inj_add_i] ^ inj_mask_i;   // checksum untouched
         end
      end
   end

   // combinational read, new value visible the cycle after a write
   for (genvar p = 0; p < 2; p++) begin : g_rd
      assign rd_val_o[p] = data_q[rd_add_i[p]];
      assign rd_chk_o[p] = chk_q[rd_add_i[p]];
   end

endmodule

// ==== read_check_stage.sv ====
/*
   SECDED check of both read ports, fully combinational
   corrected value is only meaningful when uce is low
   reads of x0 never raise ce or uce
*/
`timescale 1ns/10ps

module read_check_stage
   import rf_pkg::*;
   import secded_pkg::*;
(
   input  rf_add_t         rd_add_i  [2],    // read addresses
   input  logic [XLEN-1:0] rd_val_i  [2],    // raw words from storage
   input  chk_t            rd_chk_i  [2],    // stored checksums
   output rp_info_t        rd_info_o [2],    // error flags per port
   output logic [XLEN-1:0] rd_fix_o  [2]     // corrected words
);

   chk_t syn     [2];    // recomputed xor stored checksum
   logic syn_ok  [2];    // clean or single-bit
   logic syn_nz  [2];    // any mismatch at all
   logic add_ok  [2];    // address is not x0

   for (genvar p = 0; p < 2; p++) begin : g_port
      assign syn[p]    = secded_checksum(rd_val_i[p]) ^ rd_chk_i[p];
      assign syn_ok[p] = secded_syndrome_ok(syn[p]);
      assign syn_nz[p] = |syn[p];
      // value of x0 is never used by the core so its faults are ignored
      assign add_ok[p] = (rd_add_i[p] != '0);

      // single error in data or check bits
      assign rd_info_o[p].ce  = add_ok[p] & syn_ok[p] & syn_nz[p];
      // even-weight or unknown syndrome
      assign rd_info_o[p].uce = add_ok[p] & ~syn_ok[p];

      assign rd_fix_o[p] = secded_correct(rd_val_i[p], syn[p]);   // flip the bad bit
   end

endmodule

// ==== acm_repair_stage.sv ====
/*
   automatic correction of single-bit errors found on the read ports
   repair register is kept twice, a repair is only issued when both copies agree
   writeback always wins the write port, a blocked repair waits one cycle per write
   a repair whose register is overwritten by writeback is dropped
   port 2 requests have priority over port 1
*/
`timescale 1ns/10ps

module acm_repair_stage
   import rf_pkg::*;
   import secded_pkg::*;
(
   input  logic            s_clk_i,                      // clock
   input  logic            rst_n_i,                      // async reset, active low
   input  rf_add_t         rd_add_i    [2],              // read addresses
   input  rp_info_t        rd_info_i   [2],              // flags from the check stage
   input  logic [XLEN-1:0] rd_fix_i    [2],              // corrected words
   input  stage_dst_t      stage_dst_i [N_FWD_STAGES],   // EX, MA, WB destinations
   input  rf_wr_t          wb_wr_i,                      // writeback write
   output rf_wr_t          file_wr_o,                    // single storage write port
   output logic            ce_o        [2],              // error that gets repaired
   output logic            uce_o       [2]               // uncorrectable error
);

   logic   fwd     [2];    // value will come from a later stage
   logic   repreq  [2];    // correctable and not forwarded
   logic   repair  [2];    // request not already covered by this cycle's write
   rf_wr_t new_req;        // selected request for the repair register
   rf_wr_t rep_q   [2];    // two copies of {pending, add, val}
   rf_wr_t rep_d   [2];
   logic   rep_agree;      // copies match
   logic   fix_we;         // repair is issued this cycle

   for (genvar p = 0; p < 2; p++) begin : g_port
      // any valid in-flight destination hides the stored value
      always_comb begin
         fwd[p] = 1'b0;
         for (int s = 0; s < N_FWD_STAGES; s++) begin
            if (stage_dst_i[s].dest_valid && (stage_dst_i[s].add == rd_add_i[p])) begin
               fwd[p] = 1'b1;
            end
         end
      end

      assign repreq[p] = rd_info_i[p].ce & ~fwd[p];
      // register written this cycle gets a fresh checksum anyway
      assign repair[p] = repreq[p] & ~(file_wr_o.we & (file_wr_o.add == rd_add_i[p]));

      assign ce_o[p]  = repreq[p];
      assign uce_o[p] = rd_info_i[p].uce;
   end

   // port 2 first
   assign new_req.we  = repair[1] | repair[0];
   assign new_req.add = repair[1] ? rd_add_i[1] : rd_add_i[0];
   assign new_req.val = repair[1] ? rd_fix_i[1] : rd_fix_i[0];

   // each copy follows its own state, so an upset in one copy shows as a mismatch
   always_comb begin
      for (int c = 0; c < 2; c++) begin
         if (rep_q[c].we && wb_wr_i.we) begin
            rep_d[c]    = rep_q[c];                          // hold and retry
            rep_d[c].we = (wb_wr_i.add != rep_q[c].add);     // drop if overwritten
         end else begin
            rep_d[c] = new_req;    // old repair written or slot was empty
         end
      end
   end

   always_ff @(posedge s_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rep_q[0] <= '0;
         rep_q[1] <= '0;
      end else begin
         rep_q[0] <= rep_d[0];
         rep_q[1] <= rep_d[1];
      end
   end

   assign rep_agree = (rep_q[0] == rep_q[1]);
   assign fix_we    = rep_q[0].we & rep_agree;

   // writeback has priority on the one write port
   always_comb begin
      if (wb_wr_i.we) begin
         file_wr_o = wb_wr_i;
      end else begin
         file_wr_o.we  = fix_we;
         file_wr_o.add = rep_q[0].add;
         file_wr_o.val = rep_q[0].val;
      end
   end

endmodule

// ==== protected_rf_top.sv ====
/*
   protected register file, storage then read check then repair
   repair writes go back through the storage write port
   forwarding destinations come from the core as plain inputs
*/
`timescale 1ns/10ps

module protected_rf_top
   import rf_pkg::*;
   import secded_pkg::*;
(
   input  logic            s_clk_i,                      // clock
   input  logic            rst_n_i,                      // async reset, active low
   input  rf_wr_t          wb_wr_i,                      // writeback write
   input  stage_dst_t      stage_dst_i [N_FWD_STAGES],   // in-flight destinations
   input  rf_add_t         rd1_add_i,                    // read port 1 address
   input  rf_add_t         rd2_add_i,                    // read port 2 address
   input  logic            inj_en_i,                     // fault injection strobe
   input  rf_add_t         inj_add_i,                    // upset target
   input  logic [XLEN-1:0] inj_mask_i,                   // bits to flip
   output logic [XLEN-1:0] rd1_val_o,                    // corrected value, port 1
   output logic [XLEN-1:0] rd2_val_o,                    // corrected value, port 2
   output logic            ce_o        [2],              // repaired single error
   output logic            uce_o       [2]               // double error
);

   rf_add_t         rd_add  [2];
   logic [XLEN-1:0] rd_val  [2];    // raw words
   chk_t            rd_chk  [2];
   rp_info_t        rd_info [2];
   logic [XLEN-1:0] rd_fix  [2];    // corrected words
   rf_wr_t          file_wr;        // merged write

   assign rd_add[0] = rd1_add_i;
   assign rd_add[1] = rd2_add_i;
   assign rd1_val_o = rd_fix[0];
   assign rd2_val_o = rd_fix[1];

   rf_storage u_storage (
      .s_clk_i, .rst_n_i, .wr_i(file_wr),
      .inj_en_i, .inj_add_i, .inj_mask_i,
      .rd_add_i(rd_add), .rd_val_o(rd_val), .rd_chk_o(rd_chk)
   );

   read_check_stage u_check (
      .rd_add_i(rd_add), .rd_val_i(rd_val), .rd_chk_i(rd_chk),
      .rd_info_o(rd_info), .rd_fix_o(rd_fix)
   );

   acm_repair_stage u_acm (
      .s_clk_i, .rst_n_i, .rd_add_i(rd_add), .rd_info_i(rd_info), .rd_fix_i(rd_fix),
      .stage_dst_i, .wb_wr_i, .file_wr_o(file_wr), .ce_o, .uce_o
   );

endmodule

// ==== acm_checker.sv ====
/*
   concurrent checks on the repair stage as bound into acm_repair_stage
   sees both copies of the repair register through the bind connection
   all checks are off while reset is low
*/
`timescale 1ns/10ps

module acm_checker
   import rf_pkg::*;
(
   input logic   s_clk_i,      // clock
   input logic   rst_n_i,      // async reset, active low
   input rf_wr_t wb_wr_i,      // writeback write
   input rf_wr_t file_wr_i,    // merged storage write
   input rf_wr_t rep0_i,       // repair register, copy 0
   input rf_wr_t rep1_i        // repair register, copy 1
);

   // repair blocked by a writeback to another register keeps its slot for later
   a_wb_defers_repair: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
      (rep0_i.we && (rep0_i == rep1_i) && wb_wr_i.we && (wb_wr_i.add != rep0_i.add))
      |=> ((rep0_i == $past(rep0_i)) && (rep1_i == $past(rep1_i))))
      else $error("repair was consumed during a writeback write");

   // x0 flags are masked so no scrub may target it
   a_no_x0_repair: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
      (file_wr_i.we && !wb_wr_i.we) |-> (file_wr_i.add != '0))
      else $error("repair issued to register x0");

   // overwritten repair is dropped in both copies
   a_drop_copy0: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
      (rep0_i.we && wb_wr_i.we && (wb_wr_i.add == rep0_i.add)) |=> !rep0_i.we)
      else $error("copy 0 still pending after writeback hit its register");

   a_drop_copy1: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
      (rep1_i.we && wb_wr_i.we && (wb_wr_i.add == rep1_i.add)) |=> !rep1_i.we)
      else $error("copy 1 still pending after writeback hit its register");

endmodule

// ==== tb_protected_rf.sv ====
/*
   directed testbench for protected_rf_top
   inputs change on the falling edge, outputs are sampled 1 ns later
   a reference array tracks what each register should hold
   upsets come only from the fault injection port
*/
`timescale 1ns/10ps

module tb_protected_rf
   import rf_pkg::*;
   import secded_pkg::*;
();

   localparam rp_info_t INFO_OK    = 2'b00;
   localparam rp_info_t INFO_CE    = 2'b01;    // ce is the low bit
   localparam rp_info_t INFO_UCE   = 2'b10;
   localparam int       REPAIR_TMO = 8;        // cycles allowed for a scrub

   logic            clk;
   logic            rst_n;
   rf_wr_t          wb_wr;
   stage_dst_t      stage_dst [N_FWD_STAGES];
   rf_add_t         rd1_add;
   rf_add_t         rd2_add;
   logic            inj_en;
   rf_add_t         inj_add;
   logic [XLEN-1:0] inj_mask;
   logic [XLEN-1:0] rd1_val;
   logic [XLEN-1:0] rd2_val;
   logic            ce  [2];
   logic            uce [2];

   logic [XLEN-1:0] model [RF_DEPTH];    // expected register contents
   logic [31:0]     rng_state;
   int              err_cnt;
   int              check_cnt;

   protected_rf_top UUT (
      .s_clk_i(clk), .rst_n_i(rst_n), .wb_wr_i(wb_wr), .stage_dst_i(stage_dst),
      .rd1_add_i(rd1_add), .rd2_add_i(rd2_add),
      .inj_en_i(inj_en), .inj_add_i(inj_add), .inj_mask_i(inj_mask),
      .rd1_val_o(rd1_val), .rd2_val_o(rd2_val), .ce_o(ce), .uce_o(uce)
   );

   bind acm_repair_stage acm_checker u_acm_chk (
      .s_clk_i, .rst_n_i, .wb_wr_i, .file_wr_i(file_wr_o),
      .rep0_i(rep_q[0]), .rep1_i(rep_q[1])
   );

   always #5 clk = ~clk;    // 10 ns period

   function automatic logic [31:0] next_rand();
      rng_state ^= rng_state << 13;
      rng_state ^= rng_state >> 17;
      rng_state ^= rng_state << 5;
      return rng_state;
   endfunction

   function automatic rp_info_t port_info(logic p);
      rp_info_t info;
      info.uce = uce[p];
      info.ce  = ce[p];
      return info;
   endfunction

   task automatic check_val(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("Mismatch %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_info(string name, rp_info_t got, rp_info_t exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("Mismatch %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_port(logic p, logic [XLEN-1:0] exp_val, rp_info_t exp_info);
      if (p) check_val("rd2_val_o", rd2_val, exp_val);
      else   check_val("rd1_val_o", rd1_val, exp_val);
      check_info(p ? "uce_o/ce_o[1]" : "uce_o/ce_o[0]", port_info(p), exp_info);
   endtask

   // one writeback write, lands at the next rising edge
   task automatic write_reg(rf_add_t add, logic [XLEN-1:0] val);
      @(negedge clk);
      wb_wr.we  = 1'b1;
      wb_wr.add = add;
      wb_wr.val = val;
      model[add] = val;
      @(negedge clk);
      wb_wr.we = 1'b0;
   endtask

   // returns in the first cycle that sees the upset
   task automatic inject(rf_add_t add, logic [XLEN-1:0] mask);
      @(negedge clk);
      inj_en   = 1'b1;
      inj_add  = add;
      inj_mask = mask;
      @(negedge clk);
      inj_en = 1'b0;
   endtask

   task automatic set_reads(rf_add_t a1, rf_add_t a2);
      rd1_add = a1;
      rd2_add = a2;
   endtask

   task automatic wait_ce_clear(logic p);
      int n;
      n = 0;
      while (ce[p] && n < REPAIR_TMO) begin
         @(negedge clk);
         #1;
         n++;
      end
      if (ce[p]) begin
         err_cnt++;
         $display("Timeout: ce on read port %0d did not clear within %0d cycles",
                  p + 1, REPAIR_TMO);
      end
   endtask

   task automatic finish_test(string name, int e0);
      $display("%s: done, %0d errors", name, err_cnt - e0);
   endtask

   task automatic write_read_all();
      int      e0;
      rf_add_t a;
      e0 = err_cnt;
      a  = '0;
      repeat (RF_DEPTH) begin
         write_reg(a, next_rand());
         a = a + 1'b1;    // wraps back to x0
      end
      repeat (RF_DEPTH) begin
         @(negedge clk);
         set_reads(a, ~a);    // port 2 walks downwards
         #1;
         check_port(1'b0, model[a], INFO_OK);
         check_port(1'b1, model[~a], INFO_OK);
         a = a + 1'b1;
      end
      finish_test("write and read back", e0);
   endtask

   task automatic single_upset();
      int              e0;
      rf_add_t         r;
      logic [31:0]     rnd;
      logic [XLEN-1:0] m;
      e0  = err_cnt;
      r   = 5'd9;
      rnd = next_rand();
      m   = 32'h1 << rnd[4:0];
      inject(r, m);
      set_reads(r, 5'd3);
      #1;
      check_port(1'b0, model[r], INFO_CE);    // flagged right after the upset
      check_port(1'b1, model[5'd3], INFO_OK);
      wait_ce_clear(1'b0);
      check_port(1'b0, model[r], INFO_OK);
      inject(r, m);    // same flip again
      #1;
      check_port(1'b0, model[r], INFO_CE);    // only seen if the word was scrubbed
      wait_ce_clear(1'b0);
      finish_test("single-bit upset", e0);
   endtask

   task automatic double_upset();
      int              e0;
      rf_add_t         r;
      logic [31:0]     rnd;
      logic [XLEN-1:0] m;
      logic [XLEN-1:0] v;
      e0  = err_cnt;
      r   = 5'd17;
      rnd = next_rand();
      m   = (32'h1 << rnd[4:0]) | (32'h1 << (rnd[4:0] + 5'd1));    // two neighbours
      inject(r, m);
      set_reads(5'd2, r);
      #1;
      check_info("uce_o/ce_o[1]", port_info(1'b1), INFO_UCE);
      repeat (3) begin
         @(negedge clk);
         #1;
         check_info("uce_o/ce_o[1]", port_info(1'b1), INFO_UCE);    // never scrubbed
      end
      v = next_rand();
      write_reg(r, v);
      #1;
      check_port(1'b1, v, INFO_OK);
      finish_test("double-bit upset", e0);
   endtask

   task automatic forward_suppress();
      int              e0;
      rf_add_t         r;
      logic [31:0]     rnd;
      logic [XLEN-1:0] m;
      e0  = err_cnt;
      r   = 5'd23;
      rnd = next_rand();
      m   = 32'h1 << rnd[4:0];
      inject(r, m);
      set_reads(r, 5'd4);
      stage_dst[1].dest_valid = 1'b1;    // MA stage will write r
      stage_dst[1].add        = r;
      #1;
      check_port(1'b0, model[r], INFO_OK);
      repeat (3) begin
         @(negedge clk);
         #1;
         check_port(1'b0, model[r], INFO_OK);
      end
      @(negedge clk);
      stage_dst[1] = '0;
      #1;
      check_port(1'b0, model[r], INFO_CE);
      wait_ce_clear(1'b0);
      check_port(1'b0, model[r], INFO_OK);
      finish_test("forwarding suppression", e0);
   endtask

   task automatic repair_collision();
      int              e0;
      rf_add_t         r;
      logic [31:0]     rnd;
      logic [XLEN-1:0] m;
      logic [XLEN-1:0] v;
      e0  = err_cnt;
      r   = 5'd12;
      rnd = next_rand();
      m   = 32'h1 << rnd[4:0];
      inject(r, m);
      set_reads(5'd5, r);
      #1;
      check_port(1'b1, model[r], INFO_CE);    // repair requested this cycle
      v = next_rand();
      write_reg(r, v);    // same register in the next cycle
      #1;
      check_port(1'b1, v, INFO_OK);
      @(negedge clk);
      #1;
      check_port(1'b1, v, INFO_OK);    // dropped repair never lands
      inject(5'd13, m);
      set_reads(5'd13, 5'd14);
      #1;
      check_port(1'b0, model[5'd13], INFO_CE);
      v = next_rand();
      write_reg(5'd14, v);    // other register, repair has to wait
      #1;
      check_port(1'b0, model[5'd13], INFO_CE);
      check_port(1'b1, v, INFO_OK);
      wait_ce_clear(1'b0);
      check_port(1'b0, model[5'd13], INFO_OK);
      finish_test("repair collision", e0);
   endtask

   task automatic zero_register();
      int e0;
      e0 = err_cnt;
      inject(5'd0, 32'h0000_0100);
      set_reads(5'd0, 5'd0);
      #1;
      check_info("uce_o/ce_o[0]", port_info(1'b0), INFO_OK);
      check_info("uce_o/ce_o[1]", port_info(1'b1), INFO_OK);
      inject(5'd0, 32'h0001_0000);    // now two bits off
      repeat (2) begin
         #1;
         check_info("uce_o/ce_o[0]", port_info(1'b0), INFO_OK);
         check_info("uce_o/ce_o[1]", port_info(1'b1), INFO_OK);
         @(negedge clk);
      end
      finish_test("register x0", e0);
   endtask

   initial begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      wb_wr     = '0;
      stage_dst = '{default: '0};
      rd1_add   = '0;
      rd2_add   = '0;
      inj_en    = 1'b0;
      inj_add   = '0;
      inj_mask  = '0;
      model     = '{default: '0};    // storage resets to zero
      rng_state = 32'h29e7804c;
      err_cnt   = 0;
      check_cnt = 0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      write_read_all();
      single_upset();
      double_upset();
      forward_suppress();
      repair_collision();
      zero_register();

      $display("tests 6, checks %0d, errors %0d", check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== protected_rf.f ====
rf_pkg.sv
secded_pkg.sv
rf_storage.sv
read_check_stage.sv
acm_repair_stage.sv
protected_rf_top.sv
acm_checker.sv
tb_protected_rf.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the register file and its testbench with Verilator, then run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_protected_rf -f protected_rf.f

# a stopped assertion ends the run early, the summary line decides
out=$(./obj_dir/Vtb_protected_rf 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'All checks passed'
